// ==== rv_pkg.sv ====
package rv_pkg;

  // ALU operations, the last six are branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic {
    OP_B_RS2,
    OP_B_IMM
  } op_b_sel_e;

  // zero feeds operand a for LUI
  typedef enum logic [1:0] {
    OP_A_RS1,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    WB_ALU,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [1:0] {
    NPC_SEQ,
    NPC_JAL,
    NPC_JALR,
    NPC_BRANCH
  } next_pc_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_HALTED
  } ctrl_state_e;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_e     alu_op;
    op_a_sel_e   op_a_sel;
    op_b_sel_e   op_b_sel;
    wb_sel_e     wb_sel;
    next_pc_e    next_pc;
    logic        reg_wen;
    logic        halt;
    logic        illegal;
  } decoded_t;

  // one record per retired instruction
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] insn;
    logic        reg_wen;
    logic [4:0]  rd;
    logic [31:0] wdata;
  } retire_t;

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic [31:0]      insn,
  output rv_pkg::decoded_t dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_zero;
  logic            f7_alt;
  logic            is_lui;
  logic            is_auipc;
  logic            is_jal;
  logic            is_jalr;
  logic            is_branch;
  logic            is_op_imm;
  logic            is_op;
  logic            is_ebreak;
  logic            branch_ok;
  logic            op_imm_ok;
  logic            op_ok;
  logic [31:0]     imm;
  rv_pkg::alu_op_e arith_op;
  rv_pkg::alu_op_e branch_op;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign f7_zero = funct7 == 7'b00000_00;
  assign f7_alt  = funct7 == 7'b01000_00;

  assign is_lui    = opcode == 7'b01_101_11;
  assign is_auipc  = opcode == 7'b00_101_11;
  assign is_jal    = opcode == 7'b11_011_11;
  assign is_jalr   = (opcode == 7'b11_001_11) && (funct3 == 3'b000);
  assign is_branch = opcode == 7'b11_000_11;
  assign is_op_imm = opcode == 7'b00_100_11;
  assign is_op     = opcode == 7'b01_100_11;
  assign is_ebreak = insn == 32'b0000000_00001_00000_000_00000_11100_11;

  // funct3 010 and 011 are not branches
  assign branch_ok = (funct3 != 3'b010) && (funct3 != 3'b011);

  // shift immediates carry funct7 in the upper bits
  assign op_imm_ok = (funct3 == 3'b001) ? f7_zero :
                     (funct3 == 3'b101) ? (f7_zero || f7_alt) : 1'b1;

  // only add/sub and srl/sra have an alternate funct7, RV32M is not decoded
  assign op_ok = f7_zero || (f7_alt && ((funct3 == 3'b000) || (funct3 == 3'b101)));

  always_comb begin
    imm = 32'd0;
    if (is_lui || is_auipc) begin
      imm = {insn[31:12], 12'd0};
    end else if (is_jal) begin
      imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    end else if (is_branch) begin
      imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    end else if (is_jalr || is_op_imm) begin
      imm = {{20{insn[31]}}, insn[31:20]};
    end
  end

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (is_op && f7_alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  branch_op = rv_pkg::ALU_EQ;
      3'b001:  branch_op = rv_pkg::ALU_NE;
      3'b100:  branch_op = rv_pkg::ALU_LT;
      3'b101:  branch_op = rv_pkg::ALU_GE;
      3'b110:  branch_op = rv_pkg::ALU_LTU;
      default: branch_op = rv_pkg::ALU_GEU;
    endcase
  end

  always_comb begin
    dec          = '0;
    // LUI reads x0 so that zero plus imm also works through the rs1 path
    dec.rs1      = is_lui ? 5'd0 : insn[19:15];
    dec.rs2      = insn[24:20];
    dec.rd       = insn[11:7];
    dec.imm      = imm;
    dec.alu_op   = rv_pkg::ALU_ADD;
    dec.op_a_sel = rv_pkg::OP_A_RS1;
    dec.op_b_sel = rv_pkg::OP_B_RS2;
    dec.wb_sel   = rv_pkg::WB_ALU;
    dec.next_pc  = rv_pkg::NPC_SEQ;
    if (is_lui) begin
      dec.op_a_sel = rv_pkg::OP_A_ZERO;
      dec.op_b_sel = rv_pkg::OP_B_IMM;
      dec.reg_wen  = 1'b1;
    end else if (is_auipc) begin
      dec.op_a_sel = rv_pkg::OP_A_PC;
      dec.op_b_sel = rv_pkg::OP_B_IMM;
      dec.reg_wen  = 1'b1;
    end else if (is_jal) begin
      dec.wb_sel  = rv_pkg::WB_PC4;
      dec.next_pc = rv_pkg::NPC_JAL;
      dec.reg_wen = 1'b1;
    end else if (is_jalr) begin
      dec.wb_sel  = rv_pkg::WB_PC4;
      dec.next_pc = rv_pkg::NPC_JALR;
      dec.reg_wen = 1'b1;
    end else if (is_branch && branch_ok) begin
      dec.alu_op  = branch_op;
      dec.next_pc = rv_pkg::NPC_BRANCH;
    end else if (is_op_imm && op_imm_ok) begin
      dec.alu_op   = arith_op;
      dec.op_b_sel = rv_pkg::OP_B_IMM;
      dec.reg_wen  = 1'b1;
    end else if (is_op && op_ok) begin
      dec.alu_op  = arith_op;
      dec.reg_wen = 1'b1;
    end else if (is_ebreak) begin
      dec.halt = 1'b1;
    end else begin
      dec.illegal = 1'b1;
    end
  end

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  input  rv_pkg::alu_op_e alu_op,
  output logic [31:0]     result,
  output logic            cmp_true
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = b[4:0];
  assign eq    = a == b;
  assign lt    = $signed(a) < $signed(b);
  assign ltu   = a < b;

  // branch conditions
  always_comb begin
    case (alu_op)
      rv_pkg::ALU_EQ:  cmp_true = eq;
      rv_pkg::ALU_NE:  cmp_true = !eq;
      rv_pkg::ALU_LT:  cmp_true = lt;
      rv_pkg::ALU_GE:  cmp_true = !lt;
      rv_pkg::ALU_LTU: cmp_true = ltu;
      rv_pkg::ALU_GEU: cmp_true = !ltu;
      default:         cmp_true = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = a - b;
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SLT:  result = {31'd0, lt};
      rv_pkg::ALU_SLTU: result = {31'd0, ltu};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      // compares also show their outcome on result
      default:          result = {31'd0, cmp_true};
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        wen,
  input  logic [4:0]  rd,
  input  logic [31:0] wdata
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// ==== rv_core_ctrl.sv ====
`timescale 1ns/1ps

module rv_core_ctrl #(
  parameter int          ADDR_WIDTH = 16,
  parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [ADDR_WIDTH-1:0] wb_adr,
  input  logic [31:0]           wb_dat_i,
  input  logic                  wb_ack,
  output logic [31:0]           insn,
  input  rv_pkg::decoded_t      dec,
  input  logic [31:0]           rs1_data,
  input  logic [31:0]           rs2_data,
  output logic [31:0]           alu_a,
  output logic [31:0]           alu_b,
  output rv_pkg::alu_op_e       alu_op,
  input  logic [31:0]           alu_result,
  input  logic                  cmp_true,
  output logic                  rf_wen,
  output logic [4:0]            rf_rd,
  output logic [31:0]           rf_wdata,
  output logic                  retire_valid,
  output rv_pkg::retire_t       retire,
  output logic                  halted,
  output logic                  trap
);

  rv_pkg::ctrl_state_e state;
  logic [31:0]         pc;
  logic [31:0]         next_pc;
  logic [31:0]         pc_plus4;
  logic [31:0]         pc_target;
  logic [31:0]         jalr_target;
  logic                cyc_q;
  logic                stop;
  logic                executing;

  assign executing = state == rv_pkg::ST_EXECUTE;
  assign stop      = dec.halt || dec.illegal;

  // fetch only, the bus never writes
  assign wb_cyc = cyc_q;
  assign wb_stb = cyc_q;
  assign wb_we  = 1'b0;
  assign wb_adr = pc[ADDR_WIDTH-1:0];

  always_comb begin
    case (dec.op_a_sel)
      rv_pkg::OP_A_PC:   alu_a = pc;
      rv_pkg::OP_A_ZERO: alu_a = 32'd0;
      default:           alu_a = rs1_data;
    endcase
  end

  assign alu_b  = (dec.op_b_sel == rv_pkg::OP_B_IMM) ? dec.imm : rs2_data;
  assign alu_op = dec.alu_op;

  assign pc_plus4    = pc + 32'd4;
  assign pc_target   = pc + dec.imm;
  assign jalr_target = (rs1_data + dec.imm) & ~32'd1;

  always_comb begin
    case (dec.next_pc)
      rv_pkg::NPC_JAL:    next_pc = pc_target;
      rv_pkg::NPC_JALR:   next_pc = jalr_target;
      rv_pkg::NPC_BRANCH: next_pc = cmp_true ? pc_target : pc_plus4;
      default:            next_pc = pc_plus4;
    endcase
  end

  // writeback happens at the closing edge of execute
  assign rf_wen   = executing && dec.reg_wen;
  assign rf_rd    = dec.rd;
  assign rf_wdata = (dec.wb_sel == rv_pkg::WB_PC4) ? pc_plus4 : alu_result;

  assign halted = state == rv_pkg::ST_HALTED;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= rv_pkg::ST_FETCH;
      pc           <= RESET_PC;
      cyc_q        <= 1'b0;
      retire_valid <= 1'b0;
      trap         <= 1'b0;
    end else begin
      retire_valid <= 1'b0;
      case (state)
        rv_pkg::ST_FETCH: begin
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (wb_ack) begin
            cyc_q <= 1'b0;
            state <= rv_pkg::ST_EXECUTE;
          end
        end
        rv_pkg::ST_EXECUTE: begin
          pc           <= next_pc;
          retire_valid <= 1'b1;
          if (stop) begin
            state <= rv_pkg::ST_HALTED;
            trap  <= dec.illegal;
          end else begin
            // start the next fetch right away
            state <= rv_pkg::ST_FETCH;
            cyc_q <= 1'b1;
          end
        end
        default: begin
          // halted until reset
          cyc_q <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == rv_pkg::ST_FETCH) && cyc_q && wb_ack) begin
      insn <= wb_dat_i;
    end
    if (executing) begin
      retire.pc      <= pc;
      retire.insn    <= insn;
      retire.reg_wen <= dec.reg_wen;
      retire.rd      <= dec.rd;
      retire.wdata   <= rf_wdata;
    end
  end

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter int          ADDR_WIDTH = 16,
  parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [ADDR_WIDTH-1:0] wb_adr,
  input  logic [31:0]           wb_dat_i,
  input  logic                  wb_ack,
  output logic                  retire_valid,
  output rv_pkg::retire_t       retire,
  output logic                  halted,
  output logic                  trap
);

  logic [31:0]      insn;
  rv_pkg::decoded_t dec;
  logic [31:0]      rs1_data;
  logic [31:0]      rs2_data;
  logic [31:0]      alu_a;
  logic [31:0]      alu_b;
  rv_pkg::alu_op_e  alu_op;
  logic [31:0]      alu_result;
  logic             cmp_true;
  logic             rf_wen;
  logic [4:0]       rf_rd;
  logic [31:0]      rf_wdata;

  rv_core_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .RESET_PC   (RESET_PC)
  ) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack),
    .insn         (insn),
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_op       (alu_op),
    .alu_result   (alu_result),
    .cmp_true     (cmp_true),
    .rf_wen       (rf_wen),
    .rf_rd        (rf_rd),
    .rf_wdata     (rf_wdata),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halted       (halted),
    .trap         (trap)
  );

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  rv_alu u_alu (
    .a        (alu_a),
    .b        (alu_b),
    .alu_op   (alu_op),
    .result   (alu_result),
    .cmp_true (cmp_true)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .rd       (rf_rd),
    .wdata    (rf_wdata)
  );

endmodule

// ==== rv_core_asserts.sv ====
`timescale 1ns/1ps

module rv_core_asserts #(
  parameter int ADDR_WIDTH = 16
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  wb_cyc,
  input logic                  wb_stb,
  input logic                  wb_ack,
  input logic [ADDR_WIDTH-1:0] wb_adr,
  input logic                  retire_valid,
  input logic                  halted
);

  // cyc and stb drop in the cycle after ack
  cyc_drops_after_ack: assert property (@(posedge clk) disable iff (reset)
    (wb_cyc && wb_ack) |=> (!wb_cyc && !wb_stb))
    else $error("wb_cyc or wb_stb stayed high in the cycle after ack");

  // address held until the slave acks
  adr_stable: assert property (@(posedge clk) disable iff (reset)
    (wb_stb && !wb_ack) |=> $stable(wb_adr))
    else $error("wb_adr changed during a pending fetch");

  no_bus_when_halted: assert property (@(posedge clk) disable iff (reset) halted |-> !wb_cyc)
    else $error("wb_cyc is high in the halted state");

  retire_pulse: assert property (@(posedge clk) disable iff (reset)
    retire_valid |=> !retire_valid)
    else $error("retire_valid stayed high for more than one cycle");

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  localparam int          ADDR_WIDTH   = 16;
  localparam logic [31:0] RESET_PC     = 32'h0000_0000;
  localparam int          CLK_PERIOD   = 100;
  localparam int          N_TESTS      = 4;
  localparam int          PROG_LEN     = 64;
  localparam int          WORST_FETCH  = 5;
  localparam int          ILLEGAL_TEST = 2;
  localparam int          MEM_WORDS    = 16384;
  localparam int          TIMEOUT_NS   = N_TESTS * PROG_LEN * WORST_FETCH * CLK_PERIOD * 2;

  localparam logic [6:0]  OPC_LUI    = 7'b0110111;
  localparam logic [6:0]  OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0]  OPC_JAL    = 7'b1101111;
  localparam logic [6:0]  OPC_JALR   = 7'b1100111;
  localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
  localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0]  OPC_OP     = 7'b0110011;
  localparam logic [31:0] EBREAK     = 32'h0010_0073;

  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [ADDR_WIDTH-1:0] wb_adr;
  logic [31:0]           wb_dat_i = 32'd0;
  logic                  wb_ack = 1'b0;
  logic                  retire_valid;
  rv_pkg::retire_t       retire;
  logic                  halted;
  logic                  trap;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] regs_m [32];
  logic [31:0] pc_m;
  int          wait_left;

  rv_core_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .RESET_PC   (RESET_PC)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halted       (halted),
    .trap         (trap)
  );

  bind rv_core_top rv_core_asserts #(.ADDR_WIDTH(ADDR_WIDTH)) u_asserts (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .wb_adr       (wb_adr),
    .retire_valid (retire_valid),
    .halted       (halted)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // instruction memory answers after 0 to 3 wait states
  always @(posedge clk) begin
    if (reset) begin
      wb_ack    <= 1'b0;
      wait_left <= $urandom_range(3, 0);
    end else if (wb_ack) begin
      wb_ack    <= 1'b0;
      wait_left <= $urandom_range(3, 0);
    end else if (wb_cyc && wb_stb) begin
      if (wait_left == 0) begin
        wb_ack   <= 1'b1;
        wb_dat_i <= imem[wb_adr[15:2]];
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

  task automatic fail_and_stop();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_and_stop();
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    fail_and_stop();
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // small register pool so that results feed later instructions
  function automatic logic [4:0] pick_reg();
    int r;
    r = $urandom_range(7, 0);
    return r[4:0];
  endfunction

  function automatic logic [31:0] gen_alu();
    int          kind;
    int          f3;
    logic [31:0] word;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    kind = $urandom_range(5, 0);
    f3   = $urandom_range(7, 0);
    word = $urandom;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f7   = 7'h00;
    imm  = word[31:20];
    if (kind < 2) begin
      if (((f3 == 0) || (f3 == 5)) && word[0]) begin
        f7 = 7'h20;
      end
      return enc_r(f7, rs2, rs1, f3[2:0], rd, OPC_OP);
    end else if (kind < 4) begin
      if (f3 == 1) begin
        imm[11:5] = 7'h00;
      end
      if (f3 == 5) begin
        imm[11:5] = word[0] ? 7'h20 : 7'h00;
      end
      return enc_i(imm, rs1, f3[2:0], rd, OPC_OP_IMM);
    end else if (kind == 4) begin
      return enc_u(word[31:12], rd, OPC_LUI);
    end
    return enc_u(word[31:12], rd, OPC_AUIPC);
  endfunction

  function automatic logic is_legal(logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
      OPC_LUI, OPC_AUIPC, OPC_JAL: return 1'b1;
      OPC_JALR:   return f3 == 3'd0;
      OPC_BRANCH: return (f3 != 3'd2) && (f3 != 3'd3);
      OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          return f7 == 7'h00;
        end
        if (f3 == 3'd5) begin
          return (f7 == 7'h00) || (f7 == 7'h20);
        end
        return 1'b1;
      end
      OPC_OP:     return (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      default:    return w == EBREAK;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // architectural effect of one instruction at pc_m
  task automatic model_step(input logic [31:0] insn, output logic wen, output logic [4:0] rd,
                            output logic [31:0] wdata, output logic [31:0] npc,
                            output logic stop, output logic bad);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    f3    = insn[14:12];
    a     = regs_m[insn[19:15]];
    b     = regs_m[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_u = {insn[31:12], 12'h000};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    wen   = 1'b0;
    rd    = insn[11:7];
    wdata = 32'd0;
    npc   = pc_m + 32'd4;
    stop  = insn == EBREAK;
    bad   = !is_legal(insn);
    if (!bad && !stop) begin
      wen   = 1'b1;
      wdata = pc_m + 32'd4;
      case (insn[6:0])
        OPC_LUI:    wdata = imm_u;
        OPC_AUIPC:  wdata = pc_m + imm_u;
        OPC_JAL:    npc = pc_m + imm_j;
        OPC_JALR:   npc = (a + imm_i) & ~32'd1;
        OPC_BRANCH: begin
          wen = 1'b0;
          if (branch_taken(f3, a, b)) begin
            npc = pc_m + imm_b;
          end
        end
        OPC_OP_IMM: wdata = alu_ref(f3, (f3 == 3'd5) && insn[30], a, imm_i);
        default:    wdata = alu_ref(f3, insn[30], a, b);
      endcase
    end
  endtask

  task automatic build_program(input logic with_illegal);
    logic        landing [PROG_LEN];
    int          i;
    int          c;
    int          step;
    int          base;
    int          tgt;
    logic [31:0] w;
    // unused words decode as illegal and carry their own address
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = {a[15:0], 16'h0000};
    end
    for (int k = 0; k < PROG_LEN; k++) begin
      landing[k] = 1'b0;
    end
    i = 0;
    // jumps land at or before slot PROG_LEN-2 so that this slot is always reached
    while (i < PROG_LEN - 2) begin
      c    = $urandom_range(9, 0);
      step = $urandom_range(3, 2);
      if ((c == 0) && (i + step <= PROG_LEN - 2)) begin
        base = $urandom_range(5, 0);
        base = (base < 2) ? base : base + 2;
        imem[i] = enc_b(13'(step * 4), pick_reg(), pick_reg(), base[2:0]);
        landing[i + step] = 1'b1;
        i = i + 1;
      end else if ((c == 1) && (i + step <= PROG_LEN - 2)) begin
        imem[i] = enc_j(21'(step * 4), pick_reg());
        landing[i + step] = 1'b1;
        i = i + 1;
      end else if ((c == 2) && (i + 1 + step <= PROG_LEN - 2) && !landing[i + 1]) begin
        // base register loaded right before the jalr with bit 0 sometimes set
        base = $urandom_range(7, 1);
        tgt  = (i + 1 + step) * 4 + $urandom_range(1, 0);
        imem[i]     = enc_i(tgt[11:0], 5'd0, 3'd0, base[4:0], OPC_OP_IMM);
        imem[i + 1] = enc_i(12'h000, base[4:0], 3'd0, pick_reg(), OPC_JALR);
        landing[i + 1 + step] = 1'b1;
        i = i + 2;
      end else begin
        imem[i] = gen_alu();
        i = i + 1;
      end
    end
    if (with_illegal) begin
      do begin
        w = $urandom;
      end while (is_legal(w));
      imem[PROG_LEN - 2] = w;
    end else begin
      imem[PROG_LEN - 2] = gen_alu();
    end
    imem[PROG_LEN - 1] = EBREAK;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    pc_m = RESET_PC;
    for (int k = 0; k < 32; k++) begin
      regs_m[k] = 32'd0;
    end
  endtask

  task automatic run_program();
    logic [31:0] insn_m;
    logic [31:0] wdata;
    logic [31:0] npc;
    logic [4:0]  rd;
    logic        wen;
    logic        stop;
    logic        bad;
    logic        done;
    logic        trap_exp;
    done     = 1'b0;
    trap_exp = 1'b0;
    @(posedge clk);
    check_equal("halted", 32'(halted), 32'd0);
    check_equal("trap", 32'(trap), 32'd0);
    check_equal("retire_valid", 32'(retire_valid), 32'd0);
    check_equal("wb_cyc", 32'(wb_cyc), 32'd0);
    check_equal("wb_stb", 32'(wb_stb), 32'd0);
    while (!done) begin
      @(posedge clk);
      if (retire_valid) begin
        insn_m = imem[pc_m[15:2]];
        model_step(insn_m, wen, rd, wdata, npc, stop, bad);
        check_equal("retire.pc", retire.pc, pc_m);
        check_equal("retire.insn", retire.insn, insn_m);
        check_equal("retire.reg_wen", 32'(retire.reg_wen), 32'(wen));
        if (wen) begin
          check_equal("retire.rd", 32'(retire.rd), 32'(rd));
          check_equal("retire.wdata", retire.wdata, wdata);
          if (rd != 5'd0) begin
            regs_m[rd] = wdata;
          end
        end
        if (stop || bad) begin
          check_equal("halted", 32'(halted), 32'd1);
          check_equal("trap", 32'(trap), 32'(bad));
          trap_exp = bad;
          done     = 1'b1;
        end
        pc_m = npc;
      end
      if (wb_stb && wb_ack) begin
        check_equal("wb_adr", 32'(wb_adr), {16'd0, pc_m[15:0]});
        check_equal("wb_we", 32'(wb_we), 32'd0);
      end
    end
    // the core must stay quiet once halted
    repeat (8) begin
      @(posedge clk);
      check_equal("wb_cyc", 32'(wb_cyc), 32'd0);
      check_equal("wb_stb", 32'(wb_stb), 32'd0);
      check_equal("retire_valid", 32'(retire_valid), 32'd0);
      check_equal("halted", 32'(halted), 32'd1);
      check_equal("trap", 32'(trap), 32'(trap_exp));
    end
  endtask

  initial begin
    void'($urandom(2));
    for (int t = 0; t < N_TESTS; t++) begin
      build_program(t == ILLEGAL_TEST);
      apply_reset();
      run_program();
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== flist.f ====
rv_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_core_ctrl.sv
rv_core_top.sv
rv_core_asserts.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
